//--- design/macPkg.sv
/*
 * Shared widths, address layout and enums of the memory access controller.
 * Imported by every RTL module and by the testbench to predict commands.
 */
`default_nettype none

package macPkg;

  // Request fields
  localparam int AddrW = 32;
  localparam int TagW  = 4;
  localparam int IdW   = 3;

  // Bank-interleaved address layout
  localparam int RowW     = 11;
  localparam int BankW    = 2;
  localparam int ColW     = 8;
  localparam int NumBanks = 4;  // Also width of one-hot bank select

  localparam int RowLsb  = 19;  // Row in addr[29:19]
  localparam int BankLsb = 8;   // Bank in addr[9:8]
  localparam int ColLsb  = 0;   // Column in addr[7:0]

  // Queue entry is {addr, tag, id}
  localparam int ReqW = AddrW + TagW + IdW;

  typedef enum logic [0:0] {
    opWrite = 1'b0,
    opRead  = 1'b1
  } macOp_t;

  typedef enum logic [1:0] {
    grantNone = 2'd0,
    grantWr   = 2'd1,
    grantRd   = 2'd2
  } arbGrant_t;

endpackage

`default_nettype wire

//--- design/reqQueue.sv
/*
 * Synchronous request FIFO, one per channel. Ready is the not-full level;
 * a pop registers the head entry onto popData with a one-cycle popValid.
 */
`timescale 1ns/1ps
`default_nettype none

module reqQueue
  import macPkg::*;
#(
  parameter int QueueAw = 5  // log2 of depth
) (
  input  logic            clk,
  input  logic            resetn,
  input  logic            push,
  input  logic [ReqW-1:0] pushData,
  output logic            ready,
  output logic            empty,
  input  logic            pop,
  output logic [ReqW-1:0] popData,
  output logic            popValid
);

  localparam int Depth = 1 << QueueAw;

  logic [ReqW-1:0]    mem [Depth];
  logic [QueueAw-1:0] wrPtr;
  logic [QueueAw-1:0] rdPtr;
  logic [QueueAw:0]   count;
  logic               doPush;
  logic               doPop;

  // Count reaches Depth only when full, so the top bit is the full flag
  assign ready  = ~count[QueueAw];
  assign empty  = (count == '0);
  assign doPush = push & ready;  // Accepted even while popping
  assign doPop  = pop & ~empty;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      popValid <= 1'b0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      popValid <= doPop;
    end
  end

  // Storage and read register
  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
    if (doPop) begin
      popData <= mem[rdPtr];  // Valid one cycle after pop
    end
  end

endmodule

`default_nettype wire

//--- design/queueArbiter.sv
/*
 * Round-robin choice between the write and read queues, one pop per cycle.
 * grantOp is registered so it lines up with the popped entry.
 */
`timescale 1ns/1ps
`default_nettype none

module queueArbiter
  import macPkg::*;
(
  input  logic   clk,
  input  logic   resetn,
  input  logic   wrEmpty,
  input  logic   rdEmpty,
  output logic   wrPop,
  output logic   rdPop,
  output macOp_t grantOp
);

  arbGrant_t lastGrant;
  arbGrant_t nextGrant;

  always_comb begin
    wrPop     = 1'b0;
    rdPop     = 1'b0;
    nextGrant = grantNone;
    if (!wrEmpty && !rdEmpty) begin
      // Both waiting, take turns; write wins from idle
      if (lastGrant == grantWr) begin
        rdPop     = 1'b1;
        nextGrant = grantRd;
      end else begin
        wrPop     = 1'b1;
        nextGrant = grantWr;
      end
    end else if (!wrEmpty) begin
      wrPop     = 1'b1;
      nextGrant = grantWr;
    end else if (!rdEmpty) begin
      rdPop     = 1'b1;
      nextGrant = grantRd;
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      lastGrant <= grantNone;
      grantOp   <= opWrite;
    end else begin
      lastGrant <= nextGrant;  // Falls back to none when both empty
      if (wrPop) begin
        grantOp <= opWrite;
      end else if (rdPop) begin
        grantOp <= opRead;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/bankDecoder.sv
/*
 * Splits a popped request into row, bank and column and issues one
 * registered command with a one-hot bank select.
 */
`timescale 1ns/1ps
`default_nettype none

module bankDecoder
  import macPkg::*;
(
  input  logic                clk,
  input  logic                resetn,
  input  logic                reqValid,
  input  macOp_t              reqOp,
  input  logic [ReqW-1:0]     reqData,
  output logic                cmdValid,
  output macOp_t              cmdOp,
  output logic [NumBanks-1:0] cmdBankSel,
  output logic [RowW-1:0]     cmdRow,
  output logic [ColW-1:0]     cmdCol,
  output logic [TagW-1:0]     cmdTag,
  output logic [IdW-1:0]      cmdId
);

  logic [AddrW-1:0]    addr;
  logic [BankW-1:0]    bank;
  logic [NumBanks-1:0] bankOneHot;

  // Entry layout is {addr, tag, id}
  assign addr = reqData[ReqW-1 -: AddrW];
  assign bank = addr[BankLsb +: BankW];

  assign bankOneHot = NumBanks'(1) << bank;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      cmdValid   <= 1'b0;
      cmdBankSel <= '0;
    end else begin
      cmdValid   <= reqValid;
      cmdBankSel <= reqValid ? bankOneHot : '0;  // Zero when idle
    end
  end

  // Command fields, qualified by cmdValid
  always_ff @(posedge clk) begin
    if (reqValid) begin
      cmdOp  <= reqOp;
      cmdRow <= addr[RowLsb +: RowW];
      cmdCol <= addr[ColLsb +: ColW];
      cmdTag <= reqData[IdW +: TagW];
      cmdId  <= reqData[IdW-1:0];
    end
  end

endmodule

`default_nettype wire

//--- design/memAccessCtrl.sv
/*
 * Memory access controller front end. Write and read requests are queued,
 * arbitrated round robin and decoded into one command per cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module memAccessCtrl
  import macPkg::*;
#(
  parameter int QueueAw = 5
) (
  input  logic                clk,
  input  logic                resetn,
  // Write request channel
  input  logic                wrValid,
  input  logic [AddrW-1:0]    wrAddr,
  input  logic [TagW-1:0]     wrTag,
  input  logic [IdW-1:0]      wrId,
  output logic                wrReady,
  // Read request channel
  input  logic                rdValid,
  input  logic [AddrW-1:0]    rdAddr,
  input  logic [TagW-1:0]     rdTag,
  input  logic [IdW-1:0]      rdId,
  output logic                rdReady,
  // Command output, no back-pressure
  output logic                cmdValid,
  output macOp_t              cmdOp,
  output logic [NumBanks-1:0] cmdBankSel,
  output logic [RowW-1:0]     cmdRow,
  output logic [ColW-1:0]     cmdCol,
  output logic [TagW-1:0]     cmdTag,
  output logic [IdW-1:0]      cmdId
);

  logic            wrEmpty, rdEmpty;
  logic            wrPop, rdPop;
  logic            wrPopValid, rdPopValid;
  logic [ReqW-1:0] wrPopData, rdPopData;
  logic            popValid;
  logic [ReqW-1:0] popData;
  macOp_t          grantOp;

  reqQueue #(.QueueAw(QueueAw)) wrQueue_i (
    .clk      (clk),
    .resetn   (resetn),
    .push     (wrValid),
    .pushData ({wrAddr, wrTag, wrId}),
    .ready    (wrReady),
    .empty    (wrEmpty),
    .pop      (wrPop),
    .popData  (wrPopData),
    .popValid (wrPopValid)
  );

  reqQueue #(.QueueAw(QueueAw)) rdQueue_i (
    .clk      (clk),
    .resetn   (resetn),
    .push     (rdValid),
    .pushData ({rdAddr, rdTag, rdId}),
    .ready    (rdReady),
    .empty    (rdEmpty),
    .pop      (rdPop),
    .popData  (rdPopData),
    .popValid (rdPopValid)
  );

  queueArbiter arbiter_i (
    .clk     (clk),
    .resetn  (resetn),
    .wrEmpty (wrEmpty),
    .rdEmpty (rdEmpty),
    .wrPop   (wrPop),
    .rdPop   (rdPop),
    .grantOp (grantOp)
  );

  // Only one queue pops per cycle
  assign popValid = wrPopValid | rdPopValid;
  assign popData  = rdPopValid ? rdPopData : wrPopData;

  bankDecoder decoder_i (
    .clk        (clk),
    .resetn     (resetn),
    .reqValid   (popValid),
    .reqOp      (grantOp),
    .reqData    (popData),
    .cmdValid   (cmdValid),
    .cmdOp      (cmdOp),
    .cmdBankSel (cmdBankSel),
    .cmdRow     (cmdRow),
    .cmdCol     (cmdCol),
    .cmdTag     (cmdTag),
    .cmdId      (cmdId)
  );

endmodule

`default_nettype wire

//--- tb/memAccessCtrl_chk.sv
/*
 * Concurrent checks on queue pops, pop register and command timing.
 * Bound into every memAccessCtrl instance.
 */
`timescale 1ns/1ps
`default_nettype none

module memAccessCtrlChk
  import macPkg::*;
(
  input logic                clk,
  input logic                resetn,
  input logic                wrEmpty,
  input logic                rdEmpty,
  input logic                wrPop,
  input logic                rdPop,
  input logic                wrPopValid,
  input logic                rdPopValid,
  input logic                popValid,
  input logic                cmdValid,
  input logic [NumBanks-1:0] cmdBankSel
);

  bankSelOneHot: assert property (@(posedge clk) disable iff (!resetn)
    cmdValid |-> $onehot(cmdBankSel))
    else $error("Bank select is not one-hot on a command");

  bankSelIdle: assert property (@(posedge clk) disable iff (!resetn)
    !cmdValid |-> (cmdBankSel == '0))
    else $error("Bank select is set without a command");

  // Arbiter must never pop an empty queue
  noEmptyPop: assert property (@(posedge clk) disable iff (!resetn)
    !(wrPop && wrEmpty) && !(rdPop && rdEmpty))
    else $error("Pop raised on an empty queue");

  singlePopValid: assert property (@(posedge clk) disable iff (!resetn)
    !(wrPopValid && rdPopValid))
    else $error("Both queues present popped data at once");

  cmdAfterPop: assert property (@(posedge clk) disable iff (!resetn)
    popValid |=> cmdValid)
    else $error("Popped entry did not become a command one cycle later");

  cmdHasPop: assert property (@(posedge clk) disable iff (!resetn)
    cmdValid |-> $past(popValid))
    else $error("Command issued without a popped entry the cycle before");

endmodule

bind memAccessCtrl memAccessCtrlChk chk_i (
  .clk        (clk),
  .resetn     (resetn),
  .wrEmpty    (wrEmpty),
  .rdEmpty    (rdEmpty),
  .wrPop      (wrPop),
  .rdPop      (rdPop),
  .wrPopValid (wrPopValid),
  .rdPopValid (rdPopValid),
  .popValid   (popValid),
  .cmdValid   (cmdValid),
  .cmdBankSel (cmdBankSel)
);

`default_nettype wire

//--- tb/memAccessCtrlTb.sv
/*
 * Testbench for the memory access controller front end. Drives both request
 * channels from an LCG, predicts every command and checks it with assertions.
 */
`timescale 1ns/1ps
`default_nettype none

module memAccessCtrlTb
  import macPkg::*;
();

  localparam int CmdW    = 1 + NumBanks + RowW + ColW + TagW + IdW;
  localparam int Timeout = 300;

  logic clk;
  logic resetn;
  logic wrValid, rdValid, wrReady, rdReady;
  logic [AddrW-1:0] wrAddr, rdAddr;
  logic [TagW-1:0] wrTag, rdTag;
  logic [IdW-1:0] wrId, rdId;
  logic cmdValid;
  macOp_t cmdOp;
  logic [NumBanks-1:0] cmdBankSel;
  logic [RowW-1:0] cmdRow;
  logic [ColW-1:0] cmdCol;
  logic [TagW-1:0] cmdTag;
  logic [IdW-1:0] cmdId;

  logic [31:0] seed = 32'hc5fa;
  int cycle = 0;
  string testName = "reset";
  logic [CmdW-1:0] wrExp[$];  // Expected commands per channel
  logic [CmdW-1:0] rdExp[$];
  int wrAcc[$];               // Accept edge of each entry
  int rdAcc[$];
  bit checkLatency, checkAlternate, sawWrFull, sawRdFull, prevValid;
  macOp_t prevOp;
  int run, lastRun;

  memAccessCtrl #(.QueueAw(3)) dut_i (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] nextRandom();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Command as {op, bankSel, row, col, tag, id}
  function automatic logic [CmdW-1:0] predictCmd(macOp_t op, logic [AddrW-1:0] addr,
                                                 logic [TagW-1:0] tag, logic [IdW-1:0] id);
    logic [NumBanks-1:0] sel;
    for (int b = 0; b < NumBanks; b++) begin
      sel[b] = (addr[BankLsb +: BankW] == BankW'(b));
    end
    return {op, sel, addr[RowLsb +: RowW], addr[ColLsb +: ColW], tag, id};
  endfunction

  task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic checkValue(input logic [CmdW-1:0] expected, input logic [CmdW-1:0] actual);
    assert (actual === expected)
      else stopOnError($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                 testName, expected, actual));
  endtask

  // One falling edge of stimulus; records what the DUT will accept
  task automatic driveCycle(input bit wrOn, input bit rdOn);
    logic [31:0] r;
    @(negedge clk);
    wrValid = wrOn;
    rdValid = rdOn;
    wrAddr  = nextRandom();
    rdAddr  = nextRandom();
    r       = nextRandom();
    wrTag   = r[31 -: TagW];
    wrId    = r[27 -: IdW];
    rdTag   = r[23 -: TagW];
    rdId    = r[19 -: IdW];
    if (!wrReady) sawWrFull = 1'b1;
    if (!rdReady) sawRdFull = 1'b1;
    if (wrOn && wrReady) begin
      wrExp.push_back(predictCmd(opWrite, wrAddr, wrTag, wrId));
      wrAcc.push_back(cycle + 1);
    end
    if (rdOn && rdReady) begin
      rdExp.push_back(predictCmd(opRead, rdAddr, rdTag, rdId));
      rdAcc.push_back(cycle + 1);
    end
  endtask

  task automatic waitDrain();
    int n;
    n = 0;
    while (wrExp.size() != 0 || rdExp.size() != 0) begin
      @(posedge clk);
      n++;
      if (n > Timeout) begin
        stopOnError("Timeout waiting for accepted requests to issue");
      end
    end
  endtask

  // Command monitor
  always @(negedge clk) begin
    logic [CmdW-1:0] actual;
    int accEdge;
    bit fromRd;
    macOp_t expOp;
    if (resetn && cmdValid) begin
      actual = {cmdOp, cmdBankSel, cmdRow, cmdCol, cmdTag, cmdId};
      assert (wrExp.size() > 0 || rdExp.size() > 0)
        else stopOnError("Command issued with no pending request");
      // Opcode picks the channel only while both have requests pending
      fromRd = (wrExp.size() == 0) || (rdExp.size() > 0 && cmdOp == opRead);
      if (fromRd) begin
        checkValue(rdExp.pop_front(), actual);
        accEdge = rdAcc.pop_front();
      end else begin
        checkValue(wrExp.pop_front(), actual);
        accEdge = wrAcc.pop_front();
      end
      if (checkLatency) begin
        assert (cycle - accEdge == 2)
          else stopOnError($sformatf("CHECK FAILED %s: expected latency 2, actual %0d",
                                     testName, cycle - accEdge));
      end
      if (checkAlternate) begin
        expOp = (prevValid && prevOp == opWrite) ? opRead : opWrite;  // Write first from idle
        assert (cmdOp == expOp)
          else stopOnError($sformatf("CHECK FAILED %s: expected op %s, actual %s",
                                     testName, expOp.name(), cmdOp.name()));
      end
      run = run + 1;
    end else if (run > 0) begin
      lastRun = run;  // Length of the burst that just ended
      run = 0;
    end
    prevValid = resetn && cmdValid;
    prevOp    = cmdOp;
  end

  task automatic burstOneChannel(input bit isRead, input int n);
    testName = isRead ? "read back to back" : "write back to back";
    repeat (n) driveCycle(!isRead, isRead);
    driveCycle(1'b0, 1'b0);
    waitDrain();
    repeat (2) driveCycle(1'b0, 1'b0);
    assert (lastRun == n)
      else stopOnError($sformatf("CHECK FAILED %s: expected run %0d, actual %0d",
                                 testName, n, lastRun));
  endtask

  initial begin
    logic [31:0] r;
    resetn  = 1'b0;
    wrValid = 1'b0;
    rdValid = 1'b0;
    wrAddr  = '0;
    rdAddr  = '0;
    wrTag   = '0;
    rdTag   = '0;
    wrId    = '0;
    rdId    = '0;
    repeat (2) begin
      @(negedge clk);
      assert (!cmdValid && wrReady && rdReady) else stopOnError("Outputs not idle in reset");
    end
    resetn = 1'b1;
    @(negedge clk);
    assert (!cmdValid && wrReady && rdReady) else stopOnError("Outputs not idle after reset");

    testName     = "idle latency";
    checkLatency = 1'b1;
    repeat (12) begin
      r = nextRandom();
      driveCycle(!r[31], r[31]);
      driveCycle(1'b0, 1'b0);
      waitDrain();
    end
    checkLatency = 1'b0;

    burstOneChannel(1'b0, 6);
    burstOneChannel(1'b1, 6);

    // Both channels saturated, queues fill
    testName       = "alternation and full";
    sawWrFull      = 1'b0;
    sawRdFull      = 1'b0;
    checkAlternate = 1'b1;
    repeat (40) driveCycle(1'b1, 1'b1);
    checkAlternate = 1'b0;
    driveCycle(1'b0, 1'b0);
    waitDrain();
    assert (sawWrFull && sawRdFull) else stopOnError("Ready never fell on a full queue");

    testName = "random traffic";
    repeat (300) begin
      r = nextRandom();
      driveCycle(r[31], r[30]);
    end
    driveCycle(1'b0, 1'b0);
    waitDrain();
    repeat (5) driveCycle(1'b0, 1'b0);  // Catch stray commands

    if (wrExp.size() == 0 && rdExp.size() == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      stopOnError("Accepted requests left without a command");
    end
  end

endmodule

`default_nettype wire

//--- memAccessCtrl.f
design/macPkg.sv
design/reqQueue.sv
design/queueArbiter.sv
design/bankDecoder.sv
design/memAccessCtrl.sv
tb/memAccessCtrl_chk.sv
tb/memAccessCtrlTb.sv

//--- Makefile
# Verilator build for the memory access controller testbench

VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
TOP        = memAccessCtrlTb
FILELIST   = memAccessCtrl.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_TEXT  = Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
